// File: Bender.yml
package:
  name: ackie

sources:
  - files:
      - rtl/kmd_pkg.sv
      - rtl/uart_byte_port.sv
      - rtl/cpu_clock_gen.sv
      - rtl/run_control.sv
      - rtl/kmd_command_fsm.sv
      - rtl/ackie_top.sv
  - target: test
    files:
      - verification/tb_models.sv
      - verification/tb_ackie.sv

// File: build.f
rtl/kmd_pkg.sv
rtl/uart_byte_port.sv
rtl/cpu_clock_gen.sv
rtl/run_control.sv
rtl/kmd_command_fsm.sv
rtl/ackie_top.sv
verification/tb_models.sv
verification/tb_ackie.sv

// File: rtl/ackie_top.sv
// Top level of the debug host link. Connects the UART byte port, the kmd command
// engine and CPU run control; the CPU and its memory attach on the outside ports.

`timescale 1ns/1ps

module ackie_top (
  input  logic               Clk,
  input  logic               proc_reset,
  input  kmd_pkg::byte_t     byte_in,
  input  logic               rx_req,
  output logic               rx_ack,
  input  logic               tx_ack,
  output logic               tx_req,
  output kmd_pkg::byte_t     byte_out,
  output kmd_pkg::mem_addr_t mem_addr,
  output kmd_pkg::mem_data_t mem_dout,
  output logic               mem_wen,
  input  kmd_pkg::mem_data_t mem_din,
  input  logic               proc_fetch,
  output logic               proc_clk,
  output logic               cpu_reset
);
  import kmd_pkg::*;

  byte_t       rx_byte;
  logic        rx_valid;
  byte_t       tx_byte;
  logic        tx_start;
  logic        tx_done;
  logic        run_req;
  step_count_t run_steps;
  logic        stop_req;
  logic        pause_req;
  logic        continue_req;
  logic        reset_req;
  cpu_status_t cpu_status;
  step_count_t steps_remain;
  step_count_t steps_since_reset;

  uart_byte_port u_port (
    .Clk        (Clk),
    .proc_reset (proc_reset),
    .byte_in    (byte_in),
    .rx_req     (rx_req),
    .rx_ack     (rx_ack),
    .tx_ack     (tx_ack),
    .tx_req     (tx_req),
    .byte_out   (byte_out),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .tx_byte    (tx_byte),
    .tx_start   (tx_start),
    .tx_done    (tx_done)
  );

  kmd_command_fsm u_fsm (
    .Clk               (Clk),
    .proc_reset        (proc_reset),
    .rx_byte           (rx_byte),
    .rx_valid          (rx_valid),
    .tx_byte           (tx_byte),
    .tx_start          (tx_start),
    .tx_done           (tx_done),
    .mem_addr          (mem_addr),
    .mem_dout          (mem_dout),
    .mem_wen           (mem_wen),
    .mem_din           (mem_din),
    .run_req           (run_req),
    .run_steps         (run_steps),
    .stop_req          (stop_req),
    .pause_req         (pause_req),
    .continue_req      (continue_req),
    .reset_req         (reset_req),
    .cpu_status        (cpu_status),
    .steps_remain      (steps_remain),
    .steps_since_reset (steps_since_reset)
  );

  run_control u_run (
    .Clk               (Clk),
    .proc_reset        (proc_reset),
    .run_req           (run_req),
    .run_steps         (run_steps),
    .stop_req          (stop_req),
    .pause_req         (pause_req),
    .continue_req      (continue_req),
    .reset_req         (reset_req),
    .proc_fetch        (proc_fetch),
    .proc_clk          (proc_clk),
    .cpu_reset         (cpu_reset),
    .cpu_status        (cpu_status),
    .steps_remain      (steps_remain),
    .steps_since_reset (steps_since_reset)
  );

endmodule

// File: rtl/cpu_clock_gen.sv
// CPU clock divider. An eight-phase counter drives proc_clk high late in each period
// and flags the instruction boundary so run control can count and stop on steps.

`timescale 1ns/1ps

module cpu_clock_gen (
  input  logic Clk,
  input  logic proc_reset,
  input  logic clk_enable,  // Phase advances only while set
  input  logic restart,     // Back to phase 0, clock low
  input  logic proc_fetch,  // CPU at an instruction boundary
  output logic proc_clk,
  output logic step_end
);
  import kmd_pkg::*;

  logic [$clog2(PROC_CLK_PHASES)-1:0] phase;       // Current phase of CPU clock
  logic [$clog2(PROC_CLK_PHASES)-1:0] phase_next;

  always_comb
  begin
    if (restart)
      phase_next = '0;
    else if (!clk_enable)
      phase_next = phase;                    // Hold, clock level frozen
    else if (phase == PROC_CLK_PHASES - 1)
      phase_next = '0;                       // Wrap to start of next period
    else
      phase_next = phase + 1'b1;
  end

  always_ff @(posedge Clk)
  begin
    if (proc_reset)
    begin
      phase    <= '0;
      proc_clk <= 1'b0;
    end
    else
    begin
      phase    <= phase_next;
      proc_clk <= (phase_next >= PROC_CLK_HIGH_FIRST) && (phase_next <= PROC_CLK_HIGH_LAST);
    end
  end

  // One full instruction done, only while the clock is really advancing
  assign step_end = clk_enable && !restart && proc_fetch && (phase == STEP_END_PHASE);

endmodule

// File: rtl/kmd_command_fsm.sv
// kmd command engine. Decodes host command bytes, gathers arguments, sends replies
// and walks memory reads and writes element by element, low byte first.
// Run requests go to run control as single-cycle pulses.

`timescale 1ns/1ps

module kmd_command_fsm (
  input  logic                 Clk,
  input  logic                 proc_reset,
  input  kmd_pkg::byte_t       rx_byte,
  input  logic                 rx_valid,
  output kmd_pkg::byte_t       tx_byte,
  output logic                 tx_start,
  input  logic                 tx_done,
  output kmd_pkg::mem_addr_t   mem_addr,
  output kmd_pkg::mem_data_t   mem_dout,
  output logic                 mem_wen,
  input  kmd_pkg::mem_data_t   mem_din,
  output logic                 run_req,
  output kmd_pkg::step_count_t run_steps,
  output logic                 stop_req,
  output logic                 pause_req,
  output logic                 continue_req,
  output logic                 reset_req,
  input  kmd_pkg::cpu_status_t cpu_status,
  input  kmd_pkg::step_count_t steps_remain,
  input  kmd_pkg::step_count_t steps_since_reset
);
  import kmd_pkg::*;

  cmd_state_t  state;
  byte_t       cmd;         // Opcode being served
  logic [71:0] msg;         // Reply, next byte in the top lane
  logic [3:0]  msg_left;    // Reply bytes still to send
  logic [47:0] arg_sr;      // Argument bytes shift in from the top
  logic [47:0] arg_next;
  logic [2:0]  arg_left;    // Argument bytes still expected
  elem_count_t elem_left;   // Elements still to transfer
  logic [2:0]  elem_size;   // Bytes per element, 1 2 or 4
  logic [1:0]  byte_sel;    // Byte lane within current element
  logic        last_byte;

  // Counters go out low byte first, reply is shifted out from the top
  function automatic step_count_t byte_swap(input step_count_t v);
    return {v[7:0], v[15:8], v[23:16], v[31:24]};
  endfunction

  assign arg_next  = {rx_byte, arg_sr[47:8]};
  assign last_byte = ({1'b0, byte_sel} == elem_size - 3'd1);

  always_ff @(posedge Clk)
  begin
    if (proc_reset)
    begin
      state        <= ST_IDLE;
      msg_left     <= '0;
      arg_left     <= '0;
      elem_left    <= '0;
      byte_sel     <= '0;
      tx_start     <= 1'b0;
      mem_wen      <= 1'b0;
      run_req      <= 1'b0;
      stop_req     <= 1'b0;
      pause_req    <= 1'b0;
      continue_req <= 1'b0;
      reset_req    <= 1'b0;
    end
    else
    begin
      tx_start     <= 1'b0;  // All strobes last one cycle
      mem_wen      <= 1'b0;
      run_req      <= 1'b0;
      stop_req     <= 1'b0;
      pause_req    <= 1'b0;
      continue_req <= 1'b0;
      reset_req    <= 1'b0;
      case (state)
        ST_IDLE:
          if (rx_valid)
          begin
            cmd <= rx_byte;
            case (rx_byte)
              CMD_NOP: ;
              CMD_PING:
              begin
                msg      <= {PING_REPLY, 40'h0};
                msg_left <= 4'd4;
                state    <= ST_REPLY;
              end
              CMD_GET_STATE:
              begin
                msg      <= {cpu_status, byte_swap(steps_remain), byte_swap(steps_since_reset)};
                msg_left <= 4'd9;
                state    <= ST_REPLY;
              end
              CMD_RESET_CPU:    reset_req    <= 1'b1;
              CMD_STOP_CPU:     stop_req     <= 1'b1;
              CMD_PAUSE_CPU:    pause_req    <= 1'b1;
              CMD_CONTINUE_CPU: continue_req <= 1'b1;
              CMD_RUN:
              begin
                arg_left <= 3'd4;              // Step count
                state    <= ST_ARGS;
              end
              default:
                // Memory access, size code 3 falls through as NOP
                if ((rx_byte[7:2] == CMD_MEM_WRITE[7:2] || rx_byte[7:2] == CMD_MEM_READ[7:2])
                    && rx_byte[1:0] != 2'b11)
                begin
                  elem_size <= 3'd1 << rx_byte[1:0];
                  arg_left  <= 3'd6;           // Address then element count
                  state     <= ST_ARGS;
                end
            endcase
          end
        ST_ARGS:
          if (rx_valid)
          begin
            arg_sr   <= arg_next;
            arg_left <= arg_left - 1'b1;
            if (arg_left == 3'd1)
            begin
              if (cmd == CMD_RUN)
              begin
                run_steps <= arg_next[47:16];
                run_req   <= 1'b1;
                state     <= ST_IDLE;
              end
              else
              begin
                mem_addr  <= arg_next[15:0];   // Upper address bytes ignored
                elem_left <= arg_next[47:32];
                byte_sel  <= '0;
                mem_dout  <= '0;
                if (arg_next[47:32] == '0)
                  state <= ST_IDLE;            // Empty transfer, no traffic
                else if (cmd[3])
                  state <= ST_RD_SEND;
                else
                  state <= ST_WR_BYTE;
              end
            end
          end
        ST_REPLY:
        begin
          tx_byte  <= msg[71:64];
          msg      <= {msg[63:0], 8'h00};
          tx_start <= 1'b1;
          state    <= ST_REPLY_WAIT;
        end
        ST_REPLY_WAIT:
          if (tx_done)
          begin
            msg_left <= msg_left - 1'b1;
            state    <= (msg_left == 4'd1) ? ST_IDLE : ST_REPLY;
          end
        ST_WR_BYTE:
          if (rx_valid)
          begin
            mem_dout[{byte_sel, 3'b000} +: 8] <= rx_byte;  // Upper lanes stay zero
            if (last_byte)
            begin
              mem_wen <= 1'b1;
              state   <= ST_WR_NEXT;
            end
            else
              byte_sel <= byte_sel + 1'b1;
          end
        ST_WR_NEXT:
        begin
          mem_addr  <= mem_addr + 1'b1;        // Strobe used the old address
          mem_dout  <= '0;
          byte_sel  <= '0;
          elem_left <= elem_left - 1'b1;
          state     <= (elem_left == 16'd1) ? ST_IDLE : ST_WR_BYTE;
        end
        ST_RD_SEND:
        begin
          tx_byte  <= mem_din[{byte_sel, 3'b000} +: 8];
          tx_start <= 1'b1;
          state    <= ST_RD_WAIT;
        end
        ST_RD_WAIT:
          if (tx_done)
          begin
            if (last_byte)
            begin
              byte_sel  <= '0;
              mem_addr  <= mem_addr + 1'b1;
              elem_left <= elem_left - 1'b1;
              state     <= (elem_left == 16'd1) ? ST_IDLE : ST_RD_SEND;
            end
            else
            begin
              byte_sel <= byte_sel + 1'b1;
              state    <= ST_RD_SEND;
            end
          end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/kmd_pkg.sv
// Shared widths, kmd opcodes, status codes and state encodings for the host link.
// Imported by every RTL block that needs a typed field or a command constant.

package kmd_pkg;

  typedef logic [7:0]  byte_t;        // One UART byte
  typedef logic [15:0] mem_addr_t;    // Memory address bus
  typedef logic [31:0] mem_data_t;    // Memory data word, up to 4-byte elements
  typedef logic [31:0] step_count_t;  // CPU step counters
  typedef logic [15:0] elem_count_t;  // Elements in one memory transfer

  // Run status as reported to the host
  typedef enum logic [7:0] {
    STATUS_RESET   = 8'h00,
    STATUS_STOPPED = 8'h01,
    STATUS_RUNNING = 8'h80
  } cpu_status_t;

  localparam byte_t CMD_NOP          = 8'h00;
  localparam byte_t CMD_PING         = 8'h01;
  localparam byte_t CMD_RESET_CPU    = 8'h04;
  localparam byte_t CMD_GET_STATE    = 8'h20;
  localparam byte_t CMD_STOP_CPU     = 8'h21;
  localparam byte_t CMD_PAUSE_CPU    = 8'h22;
  localparam byte_t CMD_CONTINUE_CPU = 8'h23;
  localparam byte_t CMD_MEM_WRITE    = 8'h40;  // Low two bits give element size
  localparam byte_t CMD_MEM_READ     = 8'h48;  // Low two bits give element size
  localparam byte_t CMD_RUN          = 8'h50;

  localparam logic [31:0] PING_REPLY = "OK00";  // Sent first character first

  localparam int PROC_CLK_PHASES     = 8;  // Clk cycles per CPU clock period
  localparam int PROC_CLK_HIGH_FIRST = 5;
  localparam int PROC_CLK_HIGH_LAST  = 7;
  localparam int STEP_END_PHASE      = 6;  // Instruction boundary sampled here

  // Command FSM states
  typedef enum logic [2:0] {
    ST_IDLE,        // Wait for a command byte
    ST_ARGS,        // Collect RUN or memory arguments
    ST_REPLY,       // Start one reply byte
    ST_REPLY_WAIT,  // Wait for reply byte handshake
    ST_WR_BYTE,     // Gather bytes of a write element
    ST_WR_NEXT,     // Write strobe and address step
    ST_RD_SEND,     // Start one byte of a read element
    ST_RD_WAIT      // Wait for read byte handshake
  } cmd_state_t;

endpackage

// File: rtl/run_control.sv
// Run controller for the CPU under debug. Keeps run status and step counters and
// applies run, stop, pause, continue and reset requests at instruction boundaries.

`timescale 1ns/1ps

module run_control (
  input  logic                 Clk,
  input  logic                 proc_reset,
  input  logic                 run_req,
  input  kmd_pkg::step_count_t run_steps,     // 0 runs forever
  input  logic                 stop_req,
  input  logic                 pause_req,
  input  logic                 continue_req,
  input  logic                 reset_req,
  input  logic                 proc_fetch,
  output logic                 proc_clk,
  output logic                 cpu_reset,
  output kmd_pkg::cpu_status_t cpu_status,
  output kmd_pkg::step_count_t steps_remain,
  output kmd_pkg::step_count_t steps_since_reset
);
  import kmd_pkg::*;

  logic        clk_enable;
  logic        restart;
  logic        step_end;
  logic        run_forever;  // Current run has no step limit
  logic        stop_pend;    // Stop at next boundary
  logic        pause_pend;   // Pause at next boundary
  step_count_t remain_next;

  assign clk_enable  = (cpu_status == STATUS_RUNNING);
  assign restart     = run_req || reset_req;  // Fresh period for a new run or reset step
  assign remain_next = run_forever ? steps_remain : steps_remain - 1'b1;

  cpu_clock_gen u_clk_gen (
    .Clk        (Clk),
    .proc_reset (proc_reset),
    .clk_enable (clk_enable),
    .restart    (restart),
    .proc_fetch (proc_fetch),
    .proc_clk   (proc_clk),
    .step_end   (step_end)
  );

  always_ff @(posedge Clk)
  begin
    if (proc_reset)
    begin
      cpu_status        <= STATUS_RESET;
      steps_remain      <= '0;
      steps_since_reset <= '0;
      run_forever       <= 1'b0;
      stop_pend         <= 1'b0;
      pause_pend        <= 1'b0;
      cpu_reset         <= 1'b0;
    end
    else
    begin
      if (step_end)
      begin
        if (cpu_reset)                             // Reset step finished
        begin
          cpu_status        <= STATUS_STOPPED;
          steps_remain      <= '0;
          steps_since_reset <= '0;
        end
        else
        begin
          steps_since_reset <= steps_since_reset + 1'b1;
          steps_remain      <= remain_next;
          if (stop_pend)
          begin
            steps_remain <= '0;                    // Stop discards what is left
            cpu_status   <= STATUS_STOPPED;
            stop_pend    <= 1'b0;
            pause_pend   <= 1'b0;
          end
          else if (pause_pend)
          begin
            cpu_status <= STATUS_STOPPED;          // Remaining count kept for continue
            pause_pend <= 1'b0;
          end
          else if (!run_forever && steps_remain == 32'd1)
            cpu_status <= STATUS_STOPPED;          // Last step of a finite run
        end
      end
      // Requests override the boundary update where they collide
      if (reset_req)
      begin
        cpu_reset         <= 1'b1;                 // Held until next RUN
        cpu_status        <= STATUS_RUNNING;
        steps_remain      <= 32'd1;                // Exactly one reset step
        steps_since_reset <= '0;
        run_forever       <= 1'b0;
        stop_pend         <= 1'b0;
        pause_pend        <= 1'b0;
      end
      else if (run_req)
      begin
        cpu_reset    <= 1'b0;
        cpu_status   <= STATUS_RUNNING;
        steps_remain <= run_steps;
        run_forever  <= (run_steps == '0);
        stop_pend    <= 1'b0;
        pause_pend   <= 1'b0;
      end
      else if (stop_req)
      begin
        if (clk_enable)
          stop_pend <= 1'b1;
        else
          steps_remain <= '0;                      // Already idle, just drop the count
      end
      else if (pause_req && clk_enable)
        pause_pend <= 1'b1;
      else if (continue_req && !clk_enable && (steps_remain != '0 || run_forever))
        cpu_status <= STATUS_RUNNING;
    end
  end

endmodule

// File: rtl/uart_byte_port.sv
// Byte port to the host UART. Runs the four-phase rx_req/rx_ack and tx_req/tx_ack
// handshakes and presents whole bytes to the command FSM as single-cycle strobes.

`timescale 1ns/1ps

module uart_byte_port (
  input  logic           Clk,
  input  logic           proc_reset,
  input  kmd_pkg::byte_t byte_in,
  input  logic           rx_req,
  output logic           rx_ack,
  input  logic           tx_ack,
  output logic           tx_req,
  output kmd_pkg::byte_t byte_out,
  output kmd_pkg::byte_t rx_byte,
  output logic           rx_valid,
  input  kmd_pkg::byte_t tx_byte,
  input  logic           tx_start,
  output logic           tx_done
);

  logic tx_pend;  // Byte loaded, waiting for tx_ack to be low

  // Receive side, byte captured on rx_req and handed on when the host lets go
  always_ff @(posedge Clk)
  begin
    if (proc_reset)
    begin
      rx_ack   <= 1'b0;
      rx_valid <= 1'b0;
      rx_byte  <= '0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (rx_req && !rx_ack)
      begin
        rx_byte <= byte_in;   // Held until rx_req drops
        rx_ack  <= 1'b1;
      end
      else if (!rx_req && rx_ack)
      begin
        rx_ack   <= 1'b0;
        rx_valid <= 1'b1;     // Handshake complete, byte to the FSM
      end
    end
  end

  // Transmit side
  always_ff @(posedge Clk)
  begin
    if (proc_reset)
    begin
      tx_req   <= 1'b0;
      tx_pend  <= 1'b0;
      tx_done  <= 1'b0;
      byte_out <= '0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (tx_start && !tx_pend && !tx_req)
      begin
        byte_out <= tx_byte;  // Only taken while idle
        tx_pend  <= 1'b1;
      end
      else if (tx_pend && !tx_ack)
      begin
        tx_pend <= 1'b0;
        tx_req  <= 1'b1;      // Previous acknowledge is over
      end
      else if (tx_req && tx_ack)
      begin
        tx_req  <= 1'b0;
        tx_done <= 1'b1;
      end
    end
  end

endmodule

// File: verification/tb_ackie.sv
// Testbench for the debug host link. Acts as the host on the byte port, keeps a
// shadow memory and a run-state model, and checks replies, strobes and CPU clock edges.
// Random stimulus comes from a fixed seed so every run is repeatable.

`timescale 1ns/1ps

module tb_ackie;
  import kmd_pkg::*;

  localparam int NUM_MEM_ROUNDS  = 12;
  localparam int TEST_COUNT      = NUM_MEM_ROUNDS * 2 + 9;   // Memory rounds plus the rest
  localparam int CYCLES_PER_TEST = 4000;                     // Generous per-test budget
  localparam int WATCHDOG_CYCLES = TEST_COUNT * CYCLES_PER_TEST;
  localparam int HS_LIMIT        = 1000;                     // Cycles per handshake phase
  localparam int MAX_POLLS       = 200;                      // State polls before giving up

  logic        Clk = 1'b0;
  logic        proc_reset;
  byte_t       byte_in;
  logic        rx_req;
  logic        rx_ack;
  logic        tx_ack;
  logic        tx_req;
  byte_t       byte_out;
  mem_addr_t   mem_addr;
  mem_data_t   mem_dout;
  logic        mem_wen;
  mem_data_t   mem_din;
  logic        proc_fetch;
  logic        proc_clk;
  logic        cpu_reset;

  integer      seed = 32'he6ae39ee;
  int          errors = 0;
  int          checks = 0;
  int          wen_count = 0;   // mem_wen pulses seen
  int          proc_edges = 0;  // proc_clk rising edges seen
  int          model_since = 0; // Expected steps since CPU reset
  logic        hung = 1'b0;     // Set when a handshake never completes
  mem_data_t   shadow [0:65535];

  always #4 Clk = ~Clk;  // 8 ns period

  ackie_top DUT (
    .Clk        (Clk),
    .proc_reset (proc_reset),
    .byte_in    (byte_in),
    .rx_req     (rx_req),
    .rx_ack     (rx_ack),
    .tx_ack     (tx_ack),
    .tx_req     (tx_req),
    .byte_out   (byte_out),
    .mem_addr   (mem_addr),
    .mem_dout   (mem_dout),
    .mem_wen    (mem_wen),
    .mem_din    (mem_din),
    .proc_fetch (proc_fetch),
    .proc_clk   (proc_clk),
    .cpu_reset  (cpu_reset)
  );

  mem_model u_mem (
    .Clk      (Clk),
    .mem_addr (mem_addr),
    .mem_dout (mem_dout),
    .mem_wen  (mem_wen),
    .mem_din  (mem_din)
  );

  fetch_model u_fetch (
    .proc_fetch (proc_fetch)
  );

  always @(posedge Clk)
  begin
    if (mem_wen)
      wen_count <= wen_count + 1;
  end

  always @(posedge proc_clk)
    proc_edges <= proc_edges + 1;

  function automatic mem_data_t fill_word(input int unsigned a);
    return {16'hA5C3 ^ a[15:0], ~a[15:0]};  // Same start image as the memory model
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic handshake_timeout(input string what);
    errors++;
    hung = 1'b1;
    $display("Handshake timeout waiting for %s", what);
  endtask

  // Host to DUT byte, four-phase
  task automatic send_byte(input byte_t b);
    int wait_cycles;
    repeat (rand_range(0, 2)) @(posedge Clk);  // Random host gap
    byte_in <= b;
    rx_req  <= 1'b1;
    wait_cycles = 0;
    @(posedge Clk);
    while (!rx_ack && wait_cycles < HS_LIMIT)
    begin
      @(posedge Clk);
      wait_cycles++;
    end
    if (!rx_ack)
      handshake_timeout("rx_ack to rise");
    rx_req <= 1'b0;
    wait_cycles = 0;
    @(posedge Clk);
    while (rx_ack && wait_cycles < HS_LIMIT)
    begin
      @(posedge Clk);
      wait_cycles++;
    end
    if (rx_ack)
      handshake_timeout("rx_ack to fall");
  endtask

  // DUT to host byte, four-phase
  task automatic recv_byte(output byte_t b);
    int wait_cycles;
    wait_cycles = 0;
    @(posedge Clk);
    while (!tx_req && wait_cycles < HS_LIMIT)
    begin
      @(posedge Clk);
      wait_cycles++;
    end
    if (!tx_req)
      handshake_timeout("tx_req to rise");
    b = byte_out;                              // Stable while tx_req is high
    repeat (rand_range(0, 2)) @(posedge Clk);  // Host back-pressure
    tx_ack <= 1'b1;
    wait_cycles = 0;
    @(posedge Clk);
    while (tx_req && wait_cycles < HS_LIMIT)
    begin
      @(posedge Clk);
      wait_cycles++;
    end
    if (tx_req)
      handshake_timeout("tx_req to fall");
    tx_ack <= 1'b0;
  endtask

  task automatic send_field(input logic [31:0] v, input int n);
    for (int k = 0; k < n; k++)
      send_byte(v[8*k +: 8]);  // Low byte first
  endtask

  task automatic run_cmd(input step_count_t steps);
    send_byte(CMD_RUN);
    send_field(steps, 4);
  endtask

  task automatic ping_check;
    byte_t b;
    byte_t expected [4];
    expected = '{8'h4F, 8'h4B, 8'h30, 8'h30};  // "OK00"
    send_byte(CMD_PING);
    for (int k = 0; k < 4; k++)
    begin
      recv_byte(b);
      check_equal(b, expected[k], $sformatf("PING reply byte %0d", k));
    end
  endtask

  task automatic get_state(output logic [7:0] st, output step_count_t rem,
                           output step_count_t since);
    byte_t b;
    send_byte(CMD_GET_STATE);
    recv_byte(b);
    st = b;
    for (int k = 0; k < 4; k++)
    begin
      recv_byte(b);
      rem[8*k +: 8] = b;
    end
    for (int k = 0; k < 4; k++)
    begin
      recv_byte(b);
      since[8*k +: 8] = b;
    end
  endtask

  task automatic wait_stopped(output logic [7:0] st, output step_count_t rem,
                              output step_count_t since);
    int polls;
    polls = 0;
    get_state(st, rem, since);
    while (st == STATUS_RUNNING && polls < MAX_POLLS && !hung)
    begin
      get_state(st, rem, since);
      polls++;
    end
    if (st == STATUS_RUNNING)
    begin
      errors++;
      $display("CPU still running after %0d state polls", MAX_POLLS);
    end
  endtask

  task automatic wait_cpu_reset(input logic level);
    int wait_cycles;
    wait_cycles = 0;
    while (cpu_reset !== level && wait_cycles < 100)
    begin
      @(posedge Clk);
      wait_cycles++;
    end
    if (cpu_reset !== level)
    begin
      errors++;
      $display("cpu_reset did not go to %0b", level);
    end
  endtask

  task automatic read_check(input logic [1:0] code, input mem_addr_t addr,
                            input elem_count_t count);
    byte_t     b;
    mem_addr_t a;
    mem_data_t word;
    send_byte({CMD_MEM_READ[7:2], code});
    send_field({16'($random(seed)), addr}, 4);  // Upper address bytes are ignored
    send_field(count, 2);
    for (int e = 0; e < count; e++)
    begin
      a    = addr + e[15:0];                    // Wraps like the 16-bit bus
      word = shadow[a];
      for (int j = 0; j < (1 << code); j++)
      begin
        recv_byte(b);
        check_equal(b, word[8*j +: 8], $sformatf("read addr %h byte %0d", a, j));
      end
    end
  endtask

  task automatic mem_round;
    logic [1:0]  code;
    mem_addr_t   addr;
    elem_count_t count;
    mem_data_t   elem;
    byte_t       b;
    int          wen_before;
    code       = rand_range(0, 2);
    addr       = $random(seed);
    count      = rand_range(1, 8);
    wen_before = wen_count;
    send_byte({CMD_MEM_WRITE[7:2], code});
    send_field({16'($random(seed)), addr}, 4);
    send_field(count, 2);
    for (int e = 0; e < count; e++)
    begin
      elem = '0;                                 // Upper bytes written as zero
      for (int j = 0; j < (1 << code); j++)
      begin
        b = $random(seed);
        elem[8*j +: 8] = b;
        send_byte(b);
      end
      shadow[mem_addr_t'(addr + e[15:0])] = elem;
    end
    repeat (4) @(posedge Clk);                   // Last strobe lands 1 cycle after rx_ack
    check_equal(wen_count - wen_before, count, "mem_wen pulses per write");
    read_check(code, addr, count);
    read_check(rand_range(0, 2), addr + rand_range(0, count - 1), rand_range(1, 8));
  endtask

  task automatic zero_count_check;
    int   wen_before;
    logic tx_seen;
    wen_before = wen_count;
    tx_seen    = 1'b0;
    send_byte({CMD_MEM_WRITE[7:2], 2'd2});
    send_field($random(seed), 4);
    send_field(0, 2);
    repeat (40)
    begin
      @(posedge Clk);
      if (tx_req)
        tx_seen = 1'b1;
    end
    send_byte({CMD_MEM_READ[7:2], 2'd0});
    send_field($random(seed), 4);
    send_field(0, 2);
    repeat (40)
    begin
      @(posedge Clk);
      if (tx_req)
        tx_seen = 1'b1;
    end
    check_equal(tx_seen, 1'b0, "reply after zero-count transfer");
    check_equal(wen_count - wen_before, 0, "mem_wen after zero-count write");
  endtask

  task automatic finite_run_check;
    logic [7:0]  st;
    step_count_t rem;
    step_count_t since;
    int          n;
    int          edges0;
    n      = rand_range(1, 20);
    edges0 = proc_edges;
    run_cmd(n);
    wait_stopped(st, rem, since);
    model_since += n;
    check_equal(proc_edges - edges0, n, "proc_clk edges in finite run");
    check_equal(st, STATUS_STOPPED, "status after finite run");
    check_equal(rem, 0, "steps_remain after finite run");
    check_equal(since, model_since, "steps_since_reset after finite run");
  endtask

  task automatic pause_continue_check;
    logic [7:0]  st;
    step_count_t rem;
    step_count_t since;
    int          n;
    int          base;
    int          edges0;
    int          edges1;
    n      = rand_range(2000, 2999);
    base   = model_since;
    edges0 = proc_edges;
    run_cmd(n);
    repeat (rand_range(200, 400)) @(posedge Clk);
    send_byte(CMD_PAUSE_CPU);
    wait_stopped(st, rem, since);
    check_equal(st, STATUS_STOPPED, "status after PAUSE");
    check_equal(rem + (since - base), n, "remaining plus done steps after PAUSE");
    check_equal(since - base, proc_edges - edges0, "steps done against proc_clk edges");
    edges1 = proc_edges;
    send_byte(CMD_CONTINUE_CPU);
    repeat (160) @(posedge Clk);                 // About 20 CPU steps
    check_equal(proc_edges > edges1, 1'b1, "proc_clk resumes after CONTINUE");
    get_state(st, rem, since);
    check_equal(st, STATUS_RUNNING, "status after CONTINUE");
    send_byte(CMD_STOP_CPU);
    wait_stopped(st, rem, since);
    model_since = base + (proc_edges - edges0);
    check_equal(st, STATUS_STOPPED, "status after STOP");
    check_equal(rem, 0, "steps_remain after STOP");
    check_equal(since, model_since, "steps_since_reset after STOP");
  endtask

  task automatic reset_step_check;
    logic [7:0]  st;
    step_count_t rem;
    step_count_t since;
    int          n;
    int          edges0;
    edges0 = proc_edges;
    send_byte(CMD_RESET_CPU);
    wait_cpu_reset(1'b1);
    wait_stopped(st, rem, since);
    check_equal(proc_edges - edges0, 1, "proc_clk pulses in reset step");
    check_equal(st, STATUS_STOPPED, "status after RESET_CPU");
    check_equal(rem, 0, "steps_remain after RESET_CPU");
    check_equal(since, 0, "steps_since_reset after RESET_CPU");
    check_equal(cpu_reset, 1'b1, "cpu_reset held after reset step");
    n      = rand_range(1, 20);
    edges0 = proc_edges;
    run_cmd(n);
    wait_cpu_reset(1'b0);                        // Released by the RUN
    wait_stopped(st, rem, since);
    model_since = n;
    check_equal(proc_edges - edges0, n, "proc_clk edges in run after reset");
    check_equal(since, model_since, "steps_since_reset in run after reset");
  endtask

  task automatic report_counts;
    $display("Checks run: %0d, errors: %0d", checks, errors);
  endtask

  initial
  begin : main
    logic [7:0]  st;
    step_count_t rem;
    step_count_t since;
    byte_in    = '0;
    rx_req     = 1'b0;
    tx_ack     = 1'b0;
    proc_reset = 1'b1;
    for (int i = 0; i < 65536; i++)
      shadow[i] = fill_word(i);
    repeat (4) @(posedge Clk);
    proc_reset <= 1'b0;
    @(posedge Clk);
    ping_check();                                // PING and state after reset
    get_state(st, rem, since);
    check_equal(st, STATUS_RESET, "status after reset");
    check_equal(rem, 0, "steps_remain after reset");
    check_equal(since, 0, "steps_since_reset after reset");
    repeat (NUM_MEM_ROUNDS) mem_round();
    zero_count_check();
    ping_check();                                // Link still alive after empty transfers
    repeat (2) finite_run_check();
    pause_continue_check();
    reset_step_check();
    repeat (2) @(posedge Clk);
    report_counts();
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (!hung && cycles < WATCHDOG_CYCLES)
    begin
      @(posedge Clk);
      cycles++;
    end
    if (hung)
      $display("Run stopped because a handshake never completed");
    else
      $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("Test failures found");
    $finish;
  end

endmodule

// File: verification/tb_models.sv
// Behavioral models around the debug link for the testbench.
// A 64K-word memory with combinational read, and a CPU fetch model.

`timescale 1ns/1ps

module mem_model (
  input  logic               Clk,
  input  kmd_pkg::mem_addr_t mem_addr,
  input  kmd_pkg::mem_data_t mem_dout,
  input  logic               mem_wen,
  output kmd_pkg::mem_data_t mem_din
);
  import kmd_pkg::*;

  mem_data_t mem [0:65535];  // One word per address

  initial
  begin
    for (int i = 0; i < 65536; i++)
      mem[i] = {16'hA5C3 ^ i[15:0], ~i[15:0]};  // Fill depends on every address bit
  end

  assign mem_din = mem[mem_addr];  // Read straight through

  always @(posedge Clk)
  begin
    if (mem_wen)
      mem[mem_addr] <= mem_dout;
  end

endmodule

// CPU stand-in that is always at an instruction boundary
module fetch_model (
  output logic proc_fetch
);

  assign proc_fetch = 1'b1;  // Every CPU clock period is one step

endmodule
